// File: hdl/ttl_pkg.sv
`default_nettype none

package ttl_pkg;

    //////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////
    localparam int unsigned NUM_CHANNELS = 8;   // TTL lines
    localparam int unsigned FIFO_DEPTH   = 4;   // Entries per channel queue
    localparam int unsigned PTR_W        = $clog2(FIFO_DEPTH);
    localparam int unsigned CNT_W        = $clog2(FIFO_DEPTH + 1);  // Holds 0..DEPTH

    localparam int unsigned ADDR_W = 6;
    localparam int unsigned DATA_W = 128;
    localparam int unsigned TS_W   = 64;
    localparam int unsigned CHAN_W = 3;
    localparam int unsigned RESP_W = 2;

    //////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////
    typedef logic [ADDR_W-1:0]       addr_t;   // AXI byte address
    typedef logic [DATA_W-1:0]       data_t;   // Write beat, also one timed entry
    typedef logic [TS_W-1:0]         ts_t;     // Timestamp / time counter
    typedef logic [CHAN_W-1:0]       chan_t;
    typedef logic [NUM_CHANNELS-1:0] ttl_t;    // One bit per channel
    typedef logic [RESP_W-1:0]       resp_t;
    typedef logic [PTR_W-1:0]        ptr_t;    // Queue index
    typedef logic [CNT_W-1:0]        cnt_t;    // Queue fill level

    localparam cnt_t FIFO_FULL = cnt_t'(FIFO_DEPTH);

    // Write response codes
    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_SLVERR = 2'd2;

    //////////////////////////////////////////////////
    // Register map and entry layout
    //////////////////////////////////////////////////
    localparam addr_t ADDR_QUEUE = 6'h00;   // Push one timed entry
    localparam addr_t ADDR_CTRL  = 6'h10;   // Control word
    localparam int unsigned FLUSH_BIT = 0;  // Ctrl bit, empties queues + late flags

    localparam int unsigned TS_LSB    = 0;   // Timestamp at 63:0
    localparam int unsigned CHAN_LSB  = 64;  // Channel at 66:64
    localparam int unsigned LEVEL_BIT = 67;  // Output level

    // Write port FSM
    typedef enum logic {
        FE_IDLE,  // Waiting for AW+W together
        FE_RESP   // B pending
    } fe_state_t;

endpackage

`default_nettype wire

// File: hdl/axi_write_frontend.sv
`default_nettype none

module axi_write_frontend (
    input  wire                    s_axi_aclk,
    input  wire                    s_axi_aresetn,

    //////////////////////////////////////////////////
    // AXI4 write address / data
    //////////////////////////////////////////////////
    input  wire ttl_pkg::addr_t    s_axi_awaddr,
    input  wire                    s_axi_awvalid,
    output logic                   s_axi_awready,
    input  wire ttl_pkg::data_t    s_axi_wdata,
    input  wire                    s_axi_wvalid,
    output logic                   s_axi_wready,

    //////////////////////////////////////////////////
    // AXI4 write response
    //////////////////////////////////////////////////
    output ttl_pkg::resp_t         s_axi_bresp,
    output logic                   s_axi_bvalid,
    input  wire                    s_axi_bready,

    // Toward router and cores
    input  wire ttl_pkg::ttl_t     full,          // Per-channel back-pressure
    output logic                   entry_valid,   // One cycle per accepted entry
    output ttl_pkg::data_t         entry,
    output logic                   flush          // Registered flush pulse
);

    ttl_pkg::fe_state_t state;
    logic               is_queue;   // Address hits the entry queue
    logic               is_ctrl;    // Address hits the control word
    ttl_pkg::chan_t     wr_chan;    // Channel named in the beat
    logic               ready;      // Shared AW/W ready, also the accept strobe

    // Address decode
    assign is_queue = (s_axi_awaddr == ttl_pkg::ADDR_QUEUE);
    assign is_ctrl  = (s_axi_awaddr == ttl_pkg::ADDR_CTRL);
    assign wr_chan  = s_axi_wdata[ttl_pkg::CHAN_LSB +: ttl_pkg::CHAN_W];

    // Both halves must be present; a queue write also needs room in its channel
    assign ready = s_axi_awvalid && s_axi_wvalid
                   && (state == ttl_pkg::FE_IDLE)
                   && (!is_queue || !full[wr_chan]);

    assign s_axi_awready = ready;
    assign s_axi_wready  = ready;   // Same signal on both channels
    assign s_axi_bvalid  = (state == ttl_pkg::FE_RESP);

    // Entry goes straight to the router register
    // Lands in the FIFO one edge later, before the next write can be judged
    assign entry_valid = ready && is_queue;
    assign entry       = s_axi_wdata;

    //////////////////////////////////////////////////
    // Response FSM + flush pulse
    //////////////////////////////////////////////////
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            state       <= ttl_pkg::FE_IDLE;
            s_axi_bresp <= ttl_pkg::RESP_OKAY;
            flush       <= 1'b0;
        end else begin
            // Single-cycle pulse, cores see it on the following edge
            flush <= ready && is_ctrl && s_axi_wdata[ttl_pkg::FLUSH_BIT];

            case (state)
                ttl_pkg::FE_IDLE: begin
                    if (ready) begin
                        state <= ttl_pkg::FE_RESP;
                        // Unknown address: error reply and no side effect
                        if (is_queue || is_ctrl) begin
                            s_axi_bresp <= ttl_pkg::RESP_OKAY;
                        end else begin
                            s_axi_bresp <= ttl_pkg::RESP_SLVERR;
                        end
                    end
                end
                ttl_pkg::FE_RESP: begin
                    if (s_axi_bready) begin   // Held until host takes it
                        state <= ttl_pkg::FE_IDLE;
                    end
                end
                default: state <= ttl_pkg::FE_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/channel_router.sv
`default_nettype none

module channel_router (
    input  wire                   s_axi_aclk,
    input  wire                   s_axi_aresetn,
    input  wire                   entry_valid,   // Accepted queue write
    input  wire ttl_pkg::data_t   entry,
    output ttl_pkg::ttl_t         chan_write,    // One-hot, one cycle
    output ttl_pkg::data_t        chan_entry     // Shared by all channels
);

    ttl_pkg::chan_t dest;   // Target channel of the incoming entry
    ttl_pkg::ttl_t  onehot; // Decoded strobe before the register

    assign dest = entry[ttl_pkg::CHAN_LSB +: ttl_pkg::CHAN_W];

    // Channel number to strobe
    always_comb begin
        onehot       = '0;
        onehot[dest] = entry_valid;
    end

    //////////////////////////////////////////////////
    // Fan-out register
    //////////////////////////////////////////////////
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            chan_write <= '0;
        end else begin
            chan_write <= onehot;   // Drops back to zero when idle
        end
    end

    // Payload beside the strobe
    always_ff @(posedge s_axi_aclk) begin
        if (entry_valid) begin
            chan_entry <= entry;
        end
    end

endmodule

`default_nettype wire

// File: hdl/timed_output_core.sv
`default_nettype none

module timed_output_core (
    input  wire                   s_axi_aclk,
    input  wire                   s_axi_aresetn,
    input  wire                   flush,        // Empties queue, clears late flag
    input  wire                   auto_start,   // Global fire enable
    input  wire ttl_pkg::ts_t     counter,      // External time base
    input  wire                   write,        // Strobe from router
    input  wire ttl_pkg::data_t   din,          // Full entry, only ts + level kept
    output logic                  full,
    output logic                  ttl_out,
    output logic                  late_error    // Sticky
);

    //////////////////////////////////////////////////
    // Queue storage
    //////////////////////////////////////////////////
    ttl_pkg::ts_t  mem_ts    [ttl_pkg::FIFO_DEPTH];
    logic          mem_level [ttl_pkg::FIFO_DEPTH];

    ttl_pkg::ptr_t rd_ptr;
    ttl_pkg::ptr_t wr_ptr;
    ttl_pkg::cnt_t count;       // Entries held

    logic          empty;
    logic          push;
    logic          pop;         // Head is due this edge
    logic          late;        // Head fires past its slot
    ttl_pkg::ts_t  head_ts;
    logic          head_level;

    assign empty = (count == '0);
    assign full  = (count == ttl_pkg::FIFO_FULL);

    assign head_ts    = mem_ts[rd_ptr];
    assign head_level = mem_level[rd_ptr];

    // Front end never offers a write to a full channel; guard anyway
    assign push = write && !full;

    // Timestamp compare
    assign pop  = auto_start && !empty && (counter >= head_ts);
    assign late = pop && (counter > head_ts);   // Exact match is on time

    // Entry fields into the ring
    always_ff @(posedge s_axi_aclk) begin
        if (push) begin
            mem_ts[wr_ptr]    <= din[ttl_pkg::TS_LSB +: ttl_pkg::TS_W];
            mem_level[wr_ptr] <= din[ttl_pkg::LEVEL_BIT];
        end
    end

    //////////////////////////////////////////////////
    // Pointers, output level, late flag
    //////////////////////////////////////////////////
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            rd_ptr     <= '0;
            wr_ptr     <= '0;
            count      <= '0;
            ttl_out    <= 1'b0;
            late_error <= 1'b0;
        end else if (flush) begin
            // Drop everything queued; line keeps its level
            rd_ptr     <= '0;
            wr_ptr     <= '0;
            count      <= '0;
            late_error <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;   // Wraps, depth is a power of two
            end

            if (pop) begin
                rd_ptr  <= rd_ptr + 1'b1;
                ttl_out <= head_level;
                if (late) begin
                    late_error <= 1'b1;
                end
            end

            // Fill level
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // Idle or push+pop together
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/ttl_controller.sv
`default_nettype none

module ttl_controller (
    input  wire                    s_axi_aclk,
    input  wire                    s_axi_aresetn,

    //////////////////////////////////////////////////
    // AXI4 write port, single beat
    //////////////////////////////////////////////////
    input  wire ttl_pkg::addr_t    s_axi_awaddr,
    input  wire                    s_axi_awvalid,
    output wire                    s_axi_awready,
    input  wire ttl_pkg::data_t    s_axi_wdata,
    input  wire                    s_axi_wvalid,
    output wire                    s_axi_wready,
    output wire ttl_pkg::resp_t    s_axi_bresp,
    output wire                    s_axi_bvalid,
    input  wire                    s_axi_bready,

    // Time base
    input  wire                    auto_start,
    input  wire ttl_pkg::ts_t      counter,

    // Lines out
    output wire ttl_pkg::ttl_t     ttl_out,
    output wire ttl_pkg::ttl_t     late_error
);

    wire                 entry_valid;
    ttl_pkg::data_t      entry;
    wire                 flush;
    ttl_pkg::ttl_t       chan_write;   // One-hot from router
    ttl_pkg::data_t      chan_entry;
    ttl_pkg::ttl_t       full;         // Back-pressure per channel

    // Bus side
    axi_write_frontend u_frontend (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .full          (full),
        .entry_valid   (entry_valid),
        .entry         (entry),
        .flush         (flush)
    );

    // Entry to its channel
    channel_router u_router (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .entry_valid   (entry_valid),
        .entry         (entry),
        .chan_write    (chan_write),
        .chan_entry    (chan_entry)
    );

    //////////////////////////////////////////////////
    // One core per TTL line
    //////////////////////////////////////////////////
    for (genvar ch = 0; ch < ttl_pkg::NUM_CHANNELS; ch++) begin : g_chan
        timed_output_core u_core (
            .s_axi_aclk    (s_axi_aclk),
            .s_axi_aresetn (s_axi_aresetn),
            .flush         (flush),          // Common to all
            .auto_start    (auto_start),
            .counter       (counter),
            .write         (chan_write[ch]),
            .din           (chan_entry),
            .full          (full[ch]),
            .ttl_out       (ttl_out[ch]),
            .late_error    (late_error[ch])
        );
    end

endmodule

`default_nettype wire

// File: tests/ttl_controller_chk.sv
`default_nettype none

module ttl_controller_chk (
    input wire                s_axi_aclk,
    input wire                s_axi_aresetn,
    input wire                s_axi_awready,
    input wire                s_axi_wready,
    input wire                s_axi_bvalid,
    input wire                s_axi_bready,
    input wire                flush,         // Internal flush pulse
    input wire ttl_pkg::ttl_t late_error
);

    int unsigned fail_count = 0;   // Failed assertions so far

    //////////////////////////////////////////////////
    // Write port
    //////////////////////////////////////////////////
    a_no_ready_in_resp: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        !(s_axi_bvalid && (s_axi_awready || s_axi_wready)))
        else begin
            $error("Write ready high while a response is pending");
            fail_count++;
        end

    a_bvalid_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
        else begin
            $error("bvalid dropped before bready");
            fail_count++;
        end

    // Late flags sticky per channel
    for (genvar ch = 0; ch < ttl_pkg::NUM_CHANNELS; ch++) begin : g_late
        a_late_sticky: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
            late_error[ch] && !flush |=> late_error[ch])
            else begin
                $error("late_error[%0d] cleared without a flush", ch);
                fail_count++;
            end
    end

    a_flush_clears: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        flush |=> late_error == '0)
        else begin
            $error("late_error not cleared by flush");
            fail_count++;
        end

endmodule

`default_nettype wire

// File: tests/ttl_controller_tb.sv
`default_nettype none

module ttl_controller_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 5;    // Inputs move after the rising edge
    localparam int RESET_CYCLES = 16;
    localparam int HOLD_CYCLES  = 8;    // Time for due entries to fire
    localparam int ACCEPT_LIMIT = 20;   // Cycles to wait for ready
    localparam int ROW_CYCLES   = 40;   // Watchdog budget per row
    localparam int NCH          = ttl_pkg::NUM_CHANNELS;

    // One table row, stimulus then expected results
    typedef struct packed {
        ttl_pkg::addr_t addr;
        ttl_pkg::data_t data;
        ttl_pkg::ts_t   cnt;     // Counter held for the whole row
        logic           run;     // auto_start
        logic           block;   // Channel full, write must not go in
        ttl_pkg::resp_t resp;
        ttl_pkg::ttl_t  ttl;
        ttl_pkg::ttl_t  late;
    } row_t;

    logic           s_axi_aclk;
    logic           s_axi_aresetn;
    ttl_pkg::addr_t s_axi_awaddr;
    ttl_pkg::data_t s_axi_wdata;
    logic           s_axi_awvalid;
    logic           s_axi_wvalid;
    logic           s_axi_bready;
    logic           s_axi_awready;
    logic           s_axi_wready;
    logic           s_axi_bvalid;
    ttl_pkg::resp_t s_axi_bresp;
    logic           auto_start;
    ttl_pkg::ts_t   counter;
    ttl_pkg::ttl_t  ttl_out;
    ttl_pkg::ttl_t  late_error;

    row_t           rows[$];
    int             cur_row = -1;
    logic           table_ready = 1'b0;
    integer         seed = 35138;

    // Expected queue contents and outputs while the table is built
    ttl_pkg::ts_t   q_ts  [NCH][$];
    logic           q_lvl [NCH][$];
    ttl_pkg::ttl_t  m_ttl  = '0;
    ttl_pkg::ttl_t  m_late = '0;

    ttl_controller UUT (.*);

    bind ttl_controller ttl_controller_chk u_chk (.*);

    //////////////////////////////////////////////////
    // Failure reporting and compares
    //////////////////////////////////////////////////
    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1, "Stopped at table row %0d", cur_row);
    endtask

    task automatic check_resp(input string name, input ttl_pkg::resp_t got,
                              input ttl_pkg::resp_t exp);
        if (got !== exp) begin
            $display("ERR %s row %0d: got 0x%h expected 0x%h", name, cur_row, got, exp);
            abort_run();
        end
    endtask

    task automatic check_ttl(input string name, input ttl_pkg::ttl_t got,
                             input ttl_pkg::ttl_t exp);
        if (got !== exp) begin
            $display("ERR %s row %0d: got 0x%h expected 0x%h", name, cur_row, got, exp);
            abort_run();
        end
    endtask

    //////////////////////////////////////////////////
    // Table construction
    //////////////////////////////////////////////////
    // Timed entry, unused upper bits get noise
    function automatic ttl_pkg::data_t make_entry(input ttl_pkg::chan_t ch, input logic lvl,
                                                  input ttl_pkg::ts_t ts);
        ttl_pkg::data_t d;
        d = {$random(seed), $random(seed), $random(seed), $random(seed)};
        d[ttl_pkg::TS_LSB +: $bits(ttl_pkg::ts_t)]     = ts;
        d[ttl_pkg::CHAN_LSB +: $bits(ttl_pkg::chan_t)] = ch;
        d[ttl_pkg::LEVEL_BIT]                          = lvl;
        return d;
    endfunction

    // Pop every head that is due, one channel at a time
    task automatic fire_due(input ttl_pkg::ts_t cnt, input logic run);
        for (int ch = 0; ch < NCH; ch++) begin
            while (run && q_ts[ch].size() > 0 && cnt >= q_ts[ch][0]) begin
                m_ttl[ch]  = q_lvl[ch].pop_front();
                m_late[ch] = m_late[ch] | (cnt > q_ts[ch].pop_front());  // Past its slot
            end
        end
    endtask

    task automatic add_row(input ttl_pkg::addr_t addr, input ttl_pkg::data_t data,
                           input ttl_pkg::ts_t cnt, input logic run);
        row_t           r;
        ttl_pkg::chan_t ch;
        ch = data[ttl_pkg::CHAN_LSB +: $bits(ttl_pkg::chan_t)];
        r  = '{addr: addr, data: data, cnt: cnt, run: run, block: 1'b0,
               resp: ttl_pkg::RESP_OKAY, ttl: '0, late: '0};
        fire_due(cnt, run);   // Older entries due at the new counter
        if (addr == ttl_pkg::ADDR_QUEUE) begin
            r.block = (q_ts[ch].size() == ttl_pkg::FIFO_DEPTH);
            if (!r.block) begin
                q_ts[ch].push_back(data[ttl_pkg::TS_LSB +: $bits(ttl_pkg::ts_t)]);
                q_lvl[ch].push_back(data[ttl_pkg::LEVEL_BIT]);
            end
        end else if (addr == ttl_pkg::ADDR_CTRL) begin
            if (data[ttl_pkg::FLUSH_BIT]) begin
                for (int i = 0; i < NCH; i++) begin
                    q_ts[i].delete();
                    q_lvl[i].delete();
                end
                m_late = '0;   // Levels stay as they are
            end
        end else begin
            r.resp = ttl_pkg::RESP_SLVERR;   // Unknown address, no side effect
        end
        fire_due(cnt, run);
        r.ttl  = m_ttl;
        r.late = m_late;
        rows.push_back(r);
    endtask

    task automatic build_table();
        ttl_pkg::ts_t   base;
        ttl_pkg::data_t held;   // Last entry of the channel 5 burst
        base     = {$random(seed), $random(seed)};
        base[63] = 1'b0;        // Room for the offsets
        // Waits below its slot, then fires exactly on time
        add_row(ttl_pkg::ADDR_QUEUE, make_entry(3'd0, 1'b1, base + 64'd100), base, 1'b1);
        add_row(ttl_pkg::ADDR_CTRL, '0, base + 64'd100, 1'b1);
        // Already overdue, late on channel 1 only
        held = make_entry(3'd1, 1'($random(seed)), base + 64'd50);
        add_row(ttl_pkg::ADDR_QUEUE, held, base + 64'd100, 1'b1);
        // Due but halted, fires once auto_start rises
        held = make_entry(3'd2, 1'b1, base + 64'd200);
        add_row(ttl_pkg::ADDR_QUEUE, held, base + 64'd200, 1'b0);
        add_row(ttl_pkg::ADDR_CTRL, '0, base + 64'd200, 1'b1);
        // Bad address must leave channel 3 alone even while running
        add_row(6'h08, make_entry(3'd3, 1'b1, base), base + 64'd200, 1'b1);
        // Halted channel 5, four fit and the fifth bounces
        for (int i = 0; i <= int'(ttl_pkg::FIFO_DEPTH); i++) begin
            held = make_entry(3'd5, 1'($random(seed)), base + 64'd300 + 64'(i));
            add_row(ttl_pkg::ADDR_QUEUE, held, base + 64'd200, 1'b0);
        end
        // Flush, retry the refused entry, then let time run past everything
        add_row(ttl_pkg::ADDR_CTRL, ttl_pkg::data_t'(1), base + 64'd200, 1'b0);
        add_row(ttl_pkg::ADDR_QUEUE, held, base + 64'd200, 1'b0);
        add_row(ttl_pkg::ADDR_CTRL, '0, base + 64'd400, 1'b1);
    endtask

    //////////////////////////////////////////////////
    // Row application
    //////////////////////////////////////////////////
    task automatic apply_row(input row_t r);
        counter       = r.cnt;
        auto_start    = r.run;
        s_axi_awaddr  = r.addr;
        s_axi_wdata   = r.data;
        s_axi_awvalid = 1'b1;
        s_axi_wvalid  = 1'b1;
        repeat (ACCEPT_LIMIT) begin
            @(negedge s_axi_aclk);
            if (s_axi_awready && s_axi_wready) break;
        end
        if ((s_axi_awready && s_axi_wready) == r.block) begin
            $display("Row %0d: write %s", cur_row,
                     r.block ? "taken by a full channel" : "not accepted in time");
            abort_run();
        end
        @(posedge s_axi_aclk);   // Handshake edge, or withdraw
        #DRIVE_DELAY;
        s_axi_awvalid = 1'b0;
        s_axi_wvalid  = 1'b0;
        if (!r.block) begin
            @(negedge s_axi_aclk);
            while (!s_axi_bvalid) begin
                @(negedge s_axi_aclk);
            end
            check_resp("s_axi_bresp", s_axi_bresp, r.resp);
            @(posedge s_axi_aclk);
            #DRIVE_DELAY;
            s_axi_bready = 1'b1;   // A cycle late so B has to wait
            @(posedge s_axi_aclk);
            #DRIVE_DELAY;
            s_axi_bready = 1'b0;
        end
        repeat (HOLD_CYCLES) @(posedge s_axi_aclk);
        @(negedge s_axi_aclk);
        check_ttl("ttl_out", ttl_out, r.ttl);
        check_ttl("late_error", late_error, r.late);
        @(posedge s_axi_aclk);
        #DRIVE_DELAY;
    endtask

    initial begin
        s_axi_aclk = 1'b0;
        forever #(CLK_PERIOD / 2) s_axi_aclk = ~s_axi_aclk;
    end

    initial begin
        s_axi_aresetn = 1'b0;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        auto_start    = 1'b0;
        counter       = '0;
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge s_axi_aclk);
        #DRIVE_DELAY;
        s_axi_aresetn = 1'b1;
        @(negedge s_axi_aclk);
        check_ttl("ttl_out", ttl_out, '0);   // Reset state
        check_ttl("late_error", late_error, '0);
        if (s_axi_bvalid !== 1'b0) begin
            $display("ERR s_axi_bvalid: got 0x%h expected 0x0", s_axi_bvalid);
            abort_run();
        end
        @(posedge s_axi_aclk);
        #DRIVE_DELAY;
        foreach (rows[i]) begin
            cur_row = i;
            apply_row(rows[i]);
        end
        if (UUT.u_chk.fail_count == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("%0d assertion failures", UUT.u_chk.fail_count);
            abort_run();
        end
    end

    // Bound checker
    initial begin
        wait (UUT.u_chk.fail_count != 0);
        $display("A concurrent assertion in the bound checker failed");
        abort_run();
    end

    // Watchdog
    initial begin
        wait (table_ready);
        repeat (RESET_CYCLES + rows.size() * ROW_CYCLES) @(posedge s_axi_aclk);
        $display("Timeout: the table did not complete in time");
        abort_run();
    end

endmodule

`default_nettype wire

// File: sources.f
hdl/ttl_pkg.sv
hdl/axi_write_frontend.sv
hdl/channel_router.sv
hdl/timed_output_core.sv
hdl/ttl_controller.sv
tests/ttl_controller_chk.sv
tests/ttl_controller_tb.sv

// File: Bender.yml
package:
  name: ttl_controller

sources:
  - hdl/ttl_pkg.sv
  - hdl/axi_write_frontend.sv
  - hdl/channel_router.sv
  - hdl/timed_output_core.sv
  - hdl/ttl_controller.sv
  - target: test
    files:
      - tests/ttl_controller_chk.sv
      - tests/ttl_controller_tb.sv
